// ==== hw/cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch #(
        parameter int TLB_ENTRIES = 8,
        parameter int CACHE_LINES = 16
) (
        input  logic                           clock,
        input  logic                           arst_n,

        input  logic                           stall,
        input  logic                           jump,
        input  logic [cpu_pkg::XLEN-1:0]       jump_target,
        input  logic                           exception,
        output logic [cpu_pkg::XLEN-1:0]       pc,
        output logic [cpu_pkg::XLEN-1:0]       next_pc,
        output logic [cpu_pkg::XLEN-1:0]       instr,
        output logic                           instr_valid,
        output logic                           tlb_hit,
        output logic                           cache_hit,

        input  logic                           tlb_enable,
        input  logic                           tlb_write,
        input  logic [cpu_pkg::XLEN-1:0]       tlb_addr,
        input  logic [cpu_pkg::XLEN-1:0]       tlb_data,

        output logic                           read,
        output logic [cpu_pkg::XLEN-1:0]       addr,
        input  logic                           mem_bus_available,
        input  logic                           resp_valid,
        input  logic [cpu_pkg::XLEN-1:0]       resp_addr,
        input  logic [cpu_pkg::LINE_WIDTH-1:0] resp_data
);

        import cpu_pkg::*;

        logic [XLEN-1:0] paddr;

        assign instr_valid = cache_hit && tlb_hit;

        cpu_fetch_ctrl fetch_ctrl_i (
                .clock       (clock),
                .arst_n      (arst_n),
                .stall       (stall),
                .jump        (jump),
                .jump_target (jump_target),
                .exception   (exception),
                .instr_valid (instr_valid),
                .pc          (pc),
                .next_pc     (next_pc)
        );

        cpu_itlb #(
                .TLB_ENTRIES (TLB_ENTRIES)
        ) itlb_i (
                .clock      (clock),
                .arst_n     (arst_n),
                .tlb_enable (tlb_enable),
                .tlb_write  (tlb_write),
                .tlb_addr   (tlb_addr),
                .tlb_data   (tlb_data),
                .vaddr      (pc),
                .paddr      (paddr),
                .tlb_hit    (tlb_hit)
        );

        // lookup only with a valid translation
        cpu_icache #(
                .CACHE_LINES (CACHE_LINES)
        ) icache_i (
                .clock             (clock),
                .arst_n            (arst_n),
                .paddr             (paddr),
                .lookup            (tlb_hit),
                .mem_bus_available (mem_bus_available),
                .resp_valid        (resp_valid),
                .resp_addr         (resp_addr),
                .resp_data         (resp_data),
                .cache_hit         (cache_hit),
                .instr             (instr),
                .read              (read),
                .addr              (addr)
        );

endmodule

`default_nettype wire

// ==== hw/cpu_fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch_ctrl (
        input  logic                     clock,
        input  logic                     arst_n,
        input  logic                     stall,
        input  logic                     jump,
        input  logic [cpu_pkg::XLEN-1:0] jump_target,
        input  logic                     exception,
        input  logic                     instr_valid,
        output logic [cpu_pkg::XLEN-1:0] pc,
        output logic [cpu_pkg::XLEN-1:0] next_pc
);

        import cpu_pkg::*;

        logic [XLEN-1:0] seq_pc;
        logic            redirect;
        logic            consumed;
        logic            pc_load;

        assign seq_pc = pc + XLEN'(4);

        // exception over jump over sequential
        always_comb begin
                if (exception) begin
                        next_pc = EXC_VECTOR;
                end else if (jump) begin
                        next_pc = jump_target;
                end else begin
                        next_pc = seq_pc;
                end
        end

        assign redirect = exception || jump;
        assign consumed = instr_valid && !stall;

        // a redirect does not wait for a valid instruction
        assign pc_load = redirect || consumed;

        always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                        pc <= RESET_PC;
                end else if (pc_load) begin
                        pc <= next_pc;
                end
        end

endmodule

`default_nettype wire

// ==== hw/cpu_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_icache #(
        parameter int CACHE_LINES = 16
) (
        input  logic                           clock,
        input  logic                           arst_n,
        input  logic [cpu_pkg::XLEN-1:0]       paddr,
        input  logic                           lookup,
        input  logic                           mem_bus_available,
        input  logic                           resp_valid,
        input  logic [cpu_pkg::XLEN-1:0]       resp_addr,
        input  logic [cpu_pkg::LINE_WIDTH-1:0] resp_data,
        output logic                           cache_hit,
        output logic [cpu_pkg::XLEN-1:0]       instr,
        output logic                           read,
        output logic [cpu_pkg::XLEN-1:0]       addr
);

        import cpu_pkg::*;

        localparam int IDX_BITS = $clog2(CACHE_LINES);
        localparam int TAG_LSB = OFFSET_BITS + IDX_BITS;
        localparam int TAG_BITS = XLEN - TAG_LSB;

        logic [CACHE_LINES-1:0] valid_bits;
        logic [TAG_BITS-1:0]    tag_mem  [CACHE_LINES];
        logic [LINE_WIDTH-1:0]  data_mem [CACHE_LINES];

        refill_state_t          rf_state;
        refill_state_t          rf_next;
        logic [XLEN-1:0]        miss_addr;   // line address of the refill in flight
        logic [LINE_WIDTH-1:0]  fill_data;

        logic [IDX_BITS-1:0]    rd_idx;
        logic [TAG_BITS-1:0]    rd_tag;
        logic [IDX_BITS-1:0]    fill_idx;
        logic [TAG_BITS-1:0]    fill_tag;
        logic [LINE_WIDTH-1:0]  rd_line;
        logic                   miss;
        logic                   resp_match;

        assign rd_idx = paddr[OFFSET_BITS +: IDX_BITS];
        assign rd_tag = paddr[XLEN-1:TAG_LSB];
        assign rd_line = data_mem[rd_idx];

        assign cache_hit = lookup && valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);
        assign instr = rd_line[word_sel(paddr)*XLEN +: XLEN];

        // only a translated address may start a refill
        assign miss = lookup && !cache_hit;

        assign fill_idx = miss_addr[OFFSET_BITS +: IDX_BITS];
        assign fill_tag = miss_addr[XLEN-1:TAG_LSB];

        assign resp_match = (rf_state == RF_WAIT) && resp_valid && (resp_addr == miss_addr);

        // single cycle request, combinational on the grant
        assign read = (rf_state == RF_REQ) && mem_bus_available;
        assign addr = miss_addr;

        always_comb begin
                rf_next = rf_state;
                case (rf_state)
                        RF_IDLE: begin
                                if (miss) begin
                                        rf_next = RF_REQ;
                                end
                        end
                        RF_REQ: begin
                                if (mem_bus_available) begin
                                        rf_next = RF_WAIT;
                                end
                        end
                        RF_WAIT: begin
                                if (resp_match) begin
                                        rf_next = RF_FILL;
                                end
                        end
                        RF_FILL: begin
                                rf_next = RF_IDLE;
                        end
                        default: begin
                                rf_next = RF_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                        rf_state <= RF_IDLE;
                        miss_addr <= '0;
                        valid_bits <= '0;
                end else begin
                        rf_state <= rf_next;
                        if (rf_state == RF_IDLE && miss) begin
                                miss_addr <= line_base(paddr);
                        end
                        if (rf_state == RF_FILL) begin
                                valid_bits[fill_idx] <= 1'b1;
                        end
                end
        end

        // other responses on the bus are ignored
        always_ff @(posedge clock) begin
                if (resp_match) begin
                        fill_data <= resp_data;
                end
        end

        always_ff @(posedge clock) begin
                if (rf_state == RF_FILL) begin
                        data_mem[fill_idx] <= fill_data;
                        tag_mem[fill_idx] <= fill_tag;
                end
        end

endmodule

`default_nettype wire

// ==== hw/cpu_itlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_itlb #(
        parameter int TLB_ENTRIES = 8
) (
        input  logic                     clock,
        input  logic                     arst_n,
        input  logic                     tlb_enable,
        input  logic                     tlb_write,
        input  logic [cpu_pkg::XLEN-1:0] tlb_addr,
        input  logic [cpu_pkg::XLEN-1:0] tlb_data,
        input  logic [cpu_pkg::XLEN-1:0] vaddr,
        output logic [cpu_pkg::XLEN-1:0] paddr,
        output logic                     tlb_hit
);

        import cpu_pkg::*;

        localparam int IDX_BITS = $clog2(TLB_ENTRIES);
        localparam int TAG_BITS = VPN_WIDTH - IDX_BITS;

        logic [TLB_ENTRIES-1:0] valid;
        logic [TAG_BITS-1:0]    tag_mem [TLB_ENTRIES];
        logic [VPN_WIDTH-1:0]   ppn_mem [TLB_ENTRIES];

        logic [VPN_WIDTH-1:0]   w_vpn;
        logic [IDX_BITS-1:0]    w_idx;
        logic [TAG_BITS-1:0]    w_tag;

        logic [VPN_WIDTH-1:0]   r_vpn;
        logic [IDX_BITS-1:0]    r_idx;
        logic [TAG_BITS-1:0]    r_tag;
        logic                   entry_hit;

        // write side, indexed by the low vpn bits
        assign w_vpn = vpn_of(tlb_addr);
        assign w_idx = w_vpn[IDX_BITS-1:0];
        assign w_tag = w_vpn[VPN_WIDTH-1:IDX_BITS];

        always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                        valid <= '0;
                end else if (tlb_write) begin
                        valid[w_idx] <= 1'b1;
                end
        end

        always_ff @(posedge clock) begin
                if (tlb_write) begin
                        tag_mem[w_idx] <= w_tag;
                        ppn_mem[w_idx] <= vpn_of(tlb_data);   // physical page number
                end
        end

        // lookup side
        assign r_vpn = vpn_of(vaddr);
        assign r_idx = r_vpn[IDX_BITS-1:0];
        assign r_tag = r_vpn[VPN_WIDTH-1:IDX_BITS];

        assign entry_hit = valid[r_idx] && (tag_mem[r_idx] == r_tag);

        // disabled tlb maps one to one and always hits
        assign tlb_hit = !tlb_enable || entry_hit;

        always_comb begin
                if (tlb_enable) begin
                        paddr = {ppn_mem[r_idx], page_off(vaddr)};
                end else begin
                        paddr = vaddr;
                end
        end

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

        localparam int XLEN = 32;
        localparam int LINE_WIDTH = 128;
        localparam int PAGE_BITS = 12;
        localparam int VPN_WIDTH = XLEN - PAGE_BITS;

        localparam int WORDS_PER_LINE = LINE_WIDTH / XLEN;
        localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
        localparam int OFFSET_BITS = $clog2(LINE_WIDTH / 8);   // byte offset within a line

        localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
        localparam logic [XLEN-1:0] EXC_VECTOR = 32'h0000_0100;

        typedef enum logic [1:0] {
                RF_IDLE,
                RF_REQ,
                RF_WAIT,
                RF_FILL
        } refill_state_t;

        function automatic logic [VPN_WIDTH-1:0] vpn_of(input logic [XLEN-1:0] a);
                return a[XLEN-1:PAGE_BITS];
        endfunction

        function automatic logic [PAGE_BITS-1:0] page_off(input logic [XLEN-1:0] a);
                return a[PAGE_BITS-1:0];
        endfunction

        // clear the byte offset inside the line
        function automatic logic [XLEN-1:0] line_base(input logic [XLEN-1:0] a);
                return {a[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        endfunction

        function automatic logic [WORD_SEL_BITS-1:0] word_sel(input logic [XLEN-1:0] a);
                return a[OFFSET_BITS-1:2];
        endfunction

endpackage

`default_nettype wire

// ==== sim.f ====
hw/cpu_pkg.sv
hw/cpu_itlb.sv
hw/cpu_icache.sv
hw/cpu_fetch_ctrl.sv
hw/cpu_fetch.sv
tb/tb_clock_gen.sv
tb/cpu_fetch_chk.sv
tb/cpu_fetch_tb.sv

// ==== tb/cpu_fetch_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch_chk (
        input logic                       clock,
        input logic                       arst_n,
        input logic                       read,
        input logic                       mem_bus_available,
        input cpu_pkg::refill_state_t     rf_state,
        input logic                       cache_hit,
        input logic [cpu_pkg::XLEN-1:0]   instr
);

        import cpu_pkg::*;

        read_needs_grant: assert property (@(posedge clock) disable iff (!arst_n)
                read |-> mem_bus_available)
                else $error("read issued without bus grant");

        read_single_cycle: assert property (@(posedge clock) disable iff (!arst_n)
                read |=> !read)
                else $error("read held for two cycles");

        read_in_req: assert property (@(posedge clock) disable iff (!arst_n)
                read |-> (rf_state == RF_REQ))
                else $error("read outside of RF_REQ");

        // a hit must deliver a defined word
        hit_instr_known: assert property (@(posedge clock) disable iff (!arst_n)
                cache_hit |-> !$isunknown(instr))
                else $error("instr unknown on a cache hit");

endmodule

`default_nettype wire

// ==== tb/cpu_fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch_tb;

        import cpu_pkg::*;

        localparam int ACT_FETCH = 0;
        localparam int ACT_JUMP = 1;
        localparam int ACT_EXC = 2;
        localparam int ACT_READS = 3;
        localparam int ACT_STALL = 4;
        localparam int ACT_TLB_MISS = 5;
        localparam int ACT_TLB_WRITE = 6;

        logic clock;
        logic arst_n;
        logic stall;
        logic jump;
        logic [XLEN-1:0] jump_target;
        logic exception;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] instr;
        logic instr_valid;
        logic tlb_hit;
        logic cache_hit;
        logic tlb_enable;
        logic tlb_write;
        logic [XLEN-1:0] tlb_addr;
        logic [XLEN-1:0] tlb_data;
        logic read;
        logic [XLEN-1:0] addr;
        logic mem_bus_available;
        logic resp_valid;
        logic [XLEN-1:0] resp_addr;
        logic [LINE_WIDTH-1:0] resp_data;

        int act_q[$];
        logic [XLEN-1:0] opnd_q[$];
        logic [XLEN-1:0] exp_pc_q[$];
        logic [XLEN-1:0] exp_instr_q[$];

        int errors = 0;
        int cycles = 0;
        int cycle_limit = 1000;
        int read_count = 0;
        logic [31:0] rng = 32'haf11d57c;
        bit pending = 0;
        int resp_delay = 0;
        logic [XLEN-1:0] pend_addr;

        tb_clock_gen clock_gen_i (
                .clock  (clock),
                .arst_n (arst_n)
        );

        cpu_fetch #(
                .TLB_ENTRIES (8),
                .CACHE_LINES (16)
        ) cpu_fetch_i (
                .clock             (clock),
                .arst_n            (arst_n),
                .stall             (stall),
                .jump              (jump),
                .jump_target       (jump_target),
                .exception         (exception),
                .pc                (pc),
                .next_pc           (next_pc),
                .instr             (instr),
                .instr_valid       (instr_valid),
                .tlb_hit           (tlb_hit),
                .cache_hit         (cache_hit),
                .tlb_enable        (tlb_enable),
                .tlb_write         (tlb_write),
                .tlb_addr          (tlb_addr),
                .tlb_data          (tlb_data),
                .read              (read),
                .addr              (addr),
                .mem_bus_available (mem_bus_available),
                .resp_valid        (resp_valid),
                .resp_addr         (resp_addr),
                .resp_data         (resp_data)
        );

        bind cpu_icache cpu_fetch_chk icache_chk_i (
                .clock             (clock),
                .arst_n            (arst_n),
                .read              (read),
                .mem_bus_available (mem_bus_available),
                .rf_state          (rf_state),
                .cache_hit         (cache_hit),
                .instr             (instr)
        );

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // memory word is its byte address xor a fixed pattern
        function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] a);
                return a ^ 32'h5a5a_0000;
        endfunction

        function automatic logic [LINE_WIDTH-1:0] line_data(input logic [XLEN-1:0] base);
                return {mem_word(base + 12), mem_word(base + 8), mem_word(base + 4),
                        mem_word(base)};
        endfunction

        task automatic fail_now(input string what);
                $display("%s at %0t", what, $time);
                $display("test failed");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
                if (got !== exp) begin
                        errors++;
                        $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
                        $display("test failed");
                        $fatal(1);
                end
        endtask

        task automatic add_row(input int a, input logic [XLEN-1:0] op,
                               input logic [XLEN-1:0] ep);
                act_q.push_back(a);
                opnd_q.push_back(op);
                exp_pc_q.push_back(ep);
                exp_instr_q.push_back(mem_word(ep));
        endtask

        task automatic fetch_and_check(input logic [XLEN-1:0] ep, input logic [XLEN-1:0] ei);
                @(negedge clock);
                while (!(instr_valid === 1'b1 && stall === 1'b0)) begin
                        @(negedge clock);
                end
                check_value("pc", pc, ep);
                check_value("instr", instr, ei);
                check_value("next_pc", next_pc, ep + 32'd4);   // sequential advance
        endtask

        task automatic redirect(input logic [XLEN-1:0] target, input logic exc);
                @(posedge clock);
                jump <= 1'b1;
                jump_target <= target;
                exception <= exc;
                @(negedge clock);
                check_value("next_pc", next_pc, exc ? EXC_VECTOR : target);
                @(posedge clock);
                jump <= 1'b0;
                exception <= 1'b0;
        endtask

        task automatic hold_stall(input logic [XLEN-1:0] ep, input logic [XLEN-1:0] ei);
                @(posedge clock);
                stall <= 1'b1;
                @(negedge clock);
                while (instr_valid !== 1'b1) begin
                        @(negedge clock);
                end
                repeat (6) begin
                        check_value("pc", pc, ep);
                        check_value("instr", instr, ei);
                        @(negedge clock);
                end
                @(posedge clock);
                stall <= 1'b0;
        endtask

        task automatic tlb_miss_hold(input int n, input logic [XLEN-1:0] ep);
                @(posedge clock);
                tlb_enable <= 1'b1;
                repeat (n) begin
                        @(negedge clock);
                        check_value("tlb_hit", tlb_hit, 0);
                        check_value("instr_valid", instr_valid, 0);
                        check_value("pc", pc, ep);
                        check_value("read", read, 0);
                end
        endtask

        task automatic tlb_fill(input logic [XLEN-1:0] phys);
                @(posedge clock);
                tlb_write <= 1'b1;
                tlb_addr <= pc;
                tlb_data <= phys;
                @(posedge clock);
                tlb_write <= 1'b0;
        endtask

        // bus model samples read at the falling edge
        always @(negedge clock) begin
                if (arst_n && read === 1'b1) begin
                        if (addr[3:0] !== 4'h0)
                                fail_now("read address is not line aligned");
                        if (mem_bus_available !== 1'b1)
                                fail_now("read issued without bus grant");
                        if (pending)
                                fail_now("second read while a refill is outstanding");
                        read_count++;
                        rng = xorshift(rng);
                        resp_delay = 1 + (rng % 6);
                        pend_addr = addr;
                        pending = 1;
                end
        end

        always @(posedge clock) begin
                rng = xorshift(rng);
                mem_bus_available <= (rng[1:0] != 2'b00);   // random gaps
                resp_valid <= 1'b0;
                if (pending) begin
                        if (resp_delay == 0) begin
                                resp_valid <= 1'b1;
                                resp_addr <= pend_addr;
                                resp_data <= line_data(pend_addr);
                                pending = 0;
                        end else begin
                                resp_delay--;
                        end
                end
        end

        always @(posedge clock) begin
                cycles++;
                if (cycles > cycle_limit)
                        fail_now("timeout, fetch did not finish in time");
        end

        initial begin
                stall = 1'b0;
                jump = 1'b0;
                jump_target = '0;
                exception = 1'b0;
                tlb_enable = 1'b0;
                tlb_write = 1'b0;
                tlb_addr = '0;
                tlb_data = '0;
                mem_bus_available = 1'b0;
                resp_valid = 1'b0;
                resp_addr = '0;
                resp_data = '0;

                add_row(ACT_FETCH, 0, 32'h000);
                add_row(ACT_FETCH, 0, 32'h004);
                add_row(ACT_FETCH, 0, 32'h008);
                add_row(ACT_JUMP, 32'h000, 32'h000);
                add_row(ACT_FETCH, 0, 32'h004);
                add_row(ACT_READS, 1, 0);
                add_row(ACT_FETCH, 0, 32'h008);
                add_row(ACT_FETCH, 0, 32'h00c);
                add_row(ACT_FETCH, 0, 32'h010);
                add_row(ACT_READS, 2, 0);
                add_row(ACT_JUMP, 32'h234, 32'h234);
                add_row(ACT_FETCH, 0, 32'h238);
                add_row(ACT_EXC, 32'h500, EXC_VECTOR);
                add_row(ACT_FETCH, 0, 32'h104);
                add_row(ACT_READS, 4, 0);
                add_row(ACT_STALL, 0, 32'h108);
                add_row(ACT_FETCH, 0, 32'h108);
                add_row(ACT_TLB_MISS, 12, 32'h10c);
                add_row(ACT_TLB_WRITE, 32'h3000, 32'h10c);
                add_row(ACT_FETCH, 0, 32'h110);
                exp_instr_q[18] = mem_word(32'h310c);   // translated page
                exp_instr_q[19] = mem_word(32'h3110);
                cycle_limit = act_q.size() * 40;

                // outputs still hold their reset values before the first edge
                @(posedge arst_n);
                check_value("read", read, 0);
                check_value("instr_valid", instr_valid, 0);
                check_value("cache_hit", cache_hit, 0);
                check_value("pc", pc, RESET_PC);

                for (int i = 0; i < act_q.size(); i++) begin
                        case (act_q[i])
                                ACT_FETCH: fetch_and_check(exp_pc_q[i], exp_instr_q[i]);
                                ACT_JUMP: begin
                                        redirect(opnd_q[i], 1'b0);
                                        fetch_and_check(exp_pc_q[i], exp_instr_q[i]);
                                end
                                ACT_EXC: begin
                                        redirect(opnd_q[i], 1'b1);   // jump given too
                                        fetch_and_check(exp_pc_q[i], exp_instr_q[i]);
                                end
                                ACT_READS: check_value("read_count", read_count, opnd_q[i]);
                                ACT_STALL: hold_stall(exp_pc_q[i], exp_instr_q[i]);
                                ACT_TLB_MISS: tlb_miss_hold(opnd_q[i], exp_pc_q[i]);
                                ACT_TLB_WRITE: begin
                                        tlb_fill(opnd_q[i]);
                                        fetch_and_check(exp_pc_q[i], exp_instr_q[i]);
                                end
                                default: fail_now("unknown action in test table");
                        endcase
                end

                if (errors == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
        output logic clock,
        output logic arst_n
);

        initial begin
                clock = 1'b0;
                forever #10 clock = ~clock;   // 20 ns period
        end

        // reset released away from the active edge
        initial begin
                arst_n = 1'b0;
                repeat (8) @(posedge clock);
                @(negedge clock);
                arst_n = 1'b1;
        end

endmodule

`default_nettype wire
